// File: logic/rv32_pkg.sv
`default_nettype none

package rv32_pkg;

    // ========================================
    // Widths and basic types
    // ========================================
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned SHAMT_W    = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [31:0]           instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ALU operations, register and immediate forms share these
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // Instruction classes the core executes
    typedef enum logic [2:0] {
        OPC_NOP,
        OPC_OP,
        OPC_OP_IMM,
        OPC_LUI,
        OPC_LOAD,
        OPC_STORE
    } opcode_e;

    // ========================================
    // Encodings
    // ========================================
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // ADDI x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;
    localparam word_t  RESET_PC  = '0;

    // ========================================
    // Records between stages
    // ========================================
    // Address is a word address
    typedef struct packed {
        logic  en;
        word_t addr;
        word_t data;
    } mem_write_t;

    typedef struct packed {
        logic      valid;
        opcode_e   opcode;
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        word_t     store_data;
        word_t     imm;
        reg_addr_t rd;
    } ex_ctrl_t;

    typedef struct packed {
        logic      valid;
        opcode_e   opcode;
        reg_addr_t rd;
        word_t     alu_result;
        word_t     imm;
    } ex_result_t;

    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        word_t     value;
    } rf_write_t;

endpackage

`default_nettype wire

// File: logic/rv32_bram.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_bram #(
    parameter type         payload_t = rv32_pkg::word_t,
    parameter int unsigned DEPTH     = 1024
) (
    input  logic                     clk,
    input  rv32_pkg::mem_write_t     write,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output payload_t                 rd_data
);

    localparam int unsigned AW = $clog2(DEPTH);

    // Memory array, maps onto block RAM
    payload_t mem [DEPTH];

    // Write port, only the low address bits select the entry
    always_ff @(posedge clk) begin
        if (write.en) begin
            mem[write.addr[AW-1:0]] <= payload_t'(write.data);
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: logic/rv32_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_fetch #(
    parameter int unsigned IMEM_DEPTH = 1024
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 program_en,
    input  rv32_pkg::mem_write_t imem_write,
    output rv32_pkg::instr_t     instr,
    output logic                 instr_valid
);

    localparam int unsigned IMEM_AW = $clog2(IMEM_DEPTH);

    rv32_pkg::word_t  pc;
    rv32_pkg::word_t  pc_word;
    rv32_pkg::instr_t ram_instr;

    // PC holds at its value while a program is loaded
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= rv32_pkg::RESET_PC;
            instr_valid <= 1'b0;
        end else begin
            // Fetch issued this cycle, instruction valid next cycle
            instr_valid <= ~program_en;
            if (!program_en) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // Byte PC to word address
    assign pc_word = pc >> 2;

    rv32_bram #(
        .payload_t (rv32_pkg::instr_t),
        .DEPTH     (IMEM_DEPTH)
    ) i_imem (
        .clk     (clk),
        .write   (imem_write),
        .rd_addr (pc_word[IMEM_AW-1:0]),
        .rd_data (ram_instr)
    );

    // Bubbles reach decode as the NOP encoding
    assign instr = instr_valid ? ram_instr : rv32_pkg::NOP_INSTR;

endmodule

`default_nettype wire

// File: logic/rv32_decode.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  rv32_pkg::instr_t    instr,
    input  logic                instr_valid,
    input  rv32_pkg::rf_write_t rf_write,
    output rv32_pkg::ex_ctrl_t  ex_ctrl
);

    // Instruction fields
    logic [6:0]          opcode_bits;
    logic [2:0]          funct3;
    logic                alt_op;
    rv32_pkg::reg_addr_t rs1;
    rv32_pkg::reg_addr_t rs2;
    rv32_pkg::reg_addr_t rd;
    logic [rv32_pkg::SHAMT_W-1:0] shamt;

    // Immediates
    rv32_pkg::word_t imm_i;
    rv32_pkg::word_t imm_s;
    rv32_pkg::word_t imm_u;
    rv32_pkg::word_t shamt_ext;

    // Decoded controls and operands
    rv32_pkg::opcode_e opcode;
    rv32_pkg::alu_op_e f3_op;
    rv32_pkg::alu_op_e alu_op;
    rv32_pkg::word_t   imm;
    rv32_pkg::word_t   op_b;
    rv32_pkg::word_t   rs1_data;
    rv32_pkg::word_t   rs2_data;

    // Register file, entry 0 never written
    rv32_pkg::word_t regs [32];

    // ========================================
    // Field split
    // ========================================
    assign opcode_bits = instr[6:0];
    assign rd          = instr[11:7];
    assign funct3      = instr[14:12];
    assign rs1         = instr[19:15];
    assign rs2         = instr[24:20];
    assign shamt       = instr[24:20];
    // Bit 30 selects SUB and SRA
    assign alt_op      = instr[30];

    assign imm_i     = {{20{instr[31]}}, instr[31:20]};
    assign imm_s     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u     = {instr[31:12], 12'b0};
    assign shamt_ext = {{(rv32_pkg::XLEN-rv32_pkg::SHAMT_W){1'b0}}, shamt};

    // funct3 to ALU operation, SUB only for register form
    always_comb begin
        case (funct3)
            rv32_pkg::F3_ADD_SUB: begin
                f3_op = (alt_op && opcode_bits == rv32_pkg::OPCODE_OP) ?
                        rv32_pkg::ALU_SUB : rv32_pkg::ALU_ADD;
            end
            rv32_pkg::F3_SLL:     f3_op = rv32_pkg::ALU_SLL;
            rv32_pkg::F3_SLT:     f3_op = rv32_pkg::ALU_SLT;
            rv32_pkg::F3_SLTU:    f3_op = rv32_pkg::ALU_SLTU;
            rv32_pkg::F3_XOR:     f3_op = rv32_pkg::ALU_XOR;
            rv32_pkg::F3_SRL_SRA: f3_op = alt_op ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
            rv32_pkg::F3_OR:      f3_op = rv32_pkg::ALU_OR;
            default:              f3_op = rv32_pkg::ALU_AND;
        endcase
    end

    // ========================================
    // Class decode and operand b select
    // ========================================
    always_comb begin
        // Unknown encodings fall back to NOP
        opcode = rv32_pkg::OPC_NOP;
        alu_op = rv32_pkg::ALU_ADD;
        imm    = imm_i;
        op_b   = imm_i;
        case (opcode_bits)
            rv32_pkg::OPCODE_OP: begin
                opcode = rv32_pkg::OPC_OP;
                alu_op = f3_op;
                op_b   = rs2_data;
            end
            rv32_pkg::OPCODE_OP_IMM: begin
                opcode = rv32_pkg::OPC_OP_IMM;
                alu_op = f3_op;
                // Shifts take the shift amount, not the full immediate
                if (funct3 == rv32_pkg::F3_SLL || funct3 == rv32_pkg::F3_SRL_SRA) begin
                    op_b = shamt_ext;
                end
            end
            rv32_pkg::OPCODE_LUI: begin
                opcode = rv32_pkg::OPC_LUI;
                imm    = imm_u;
                op_b   = imm_u;
            end
            rv32_pkg::OPCODE_LOAD: begin
                opcode = rv32_pkg::OPC_LOAD;
            end
            rv32_pkg::OPCODE_STORE: begin
                opcode = rv32_pkg::OPC_STORE;
                imm    = imm_s;
                op_b   = imm_s;
            end
            default: begin
                opcode = rv32_pkg::OPC_NOP;
            end
        endcase
    end

    // ========================================
    // Register file
    // ========================================
    always_ff @(posedge clk) begin
        if (rf_write.en && rf_write.rd != '0) begin
            regs[rf_write.rd] <= rf_write.value;
        end
    end

    // x0 reads zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // Decode-to-execute register, control part
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_ctrl.valid  <= 1'b0;
            ex_ctrl.opcode <= rv32_pkg::OPC_NOP;
        end else begin
            ex_ctrl.valid  <= instr_valid;
            ex_ctrl.opcode <= opcode;
        end
    end

    // Payload part
    always_ff @(posedge clk) begin
        ex_ctrl.alu_op     <= alu_op;
        ex_ctrl.op_a       <= rs1_data;
        ex_ctrl.op_b       <= op_b;
        ex_ctrl.store_data <= rs2_data;
        ex_ctrl.imm        <= imm;
        ex_ctrl.rd         <= rd;
    end

endmodule

`default_nettype wire

// File: logic/rv32_alu.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_alu (
    input  rv32_pkg::ex_ctrl_t   ex_ctrl,
    input  logic                 clk,
    input  logic                 rst_n,
    output rv32_pkg::ex_result_t result,
    output rv32_pkg::word_t      addr
);

    rv32_pkg::word_t alu_out;
    logic [rv32_pkg::SHAMT_W-1:0] sh;

    // Shifts use the low five bits of operand b
    assign sh = ex_ctrl.op_b[rv32_pkg::SHAMT_W-1:0];

    always_comb begin
        case (ex_ctrl.alu_op)
            rv32_pkg::ALU_SUB:  alu_out = ex_ctrl.op_a - ex_ctrl.op_b;
            rv32_pkg::ALU_AND:  alu_out = ex_ctrl.op_a & ex_ctrl.op_b;
            rv32_pkg::ALU_OR:   alu_out = ex_ctrl.op_a | ex_ctrl.op_b;
            rv32_pkg::ALU_XOR:  alu_out = ex_ctrl.op_a ^ ex_ctrl.op_b;
            rv32_pkg::ALU_SLT:  alu_out = {31'b0, $signed(ex_ctrl.op_a) < $signed(ex_ctrl.op_b)};
            rv32_pkg::ALU_SLTU: alu_out = {31'b0, ex_ctrl.op_a < ex_ctrl.op_b};
            rv32_pkg::ALU_SLL:  alu_out = ex_ctrl.op_a << sh;
            rv32_pkg::ALU_SRL:  alu_out = ex_ctrl.op_a >> sh;
            rv32_pkg::ALU_SRA:  alu_out = $unsigned($signed(ex_ctrl.op_a) >>> sh);
            // ADD, also the load and store address
            default:            alu_out = ex_ctrl.op_a + ex_ctrl.op_b;
        endcase
    end

    // Data RAM address goes out in the same cycle
    assign addr = alu_out;

    // Result record, control part
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result.valid  <= 1'b0;
            result.opcode <= rv32_pkg::OPC_NOP;
        end else begin
            result.valid  <= ex_ctrl.valid;
            result.opcode <= ex_ctrl.opcode;
        end
    end

    always_ff @(posedge clk) begin
        result.rd         <= ex_ctrl.rd;
        result.alu_result <= alu_out;
        result.imm        <= ex_ctrl.imm;
    end

endmodule

`default_nettype wire

// File: logic/rv32_dmem_unit.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_dmem_unit #(
    parameter int unsigned DMEM_DEPTH = 1024
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 program_en,
    input  rv32_pkg::mem_write_t dmem_write,
    input  rv32_pkg::ex_ctrl_t   ex_ctrl,
    input  rv32_pkg::word_t      addr,
    output rv32_pkg::word_t      load_data
);

    localparam int unsigned DMEM_AW = $clog2(DMEM_DEPTH);

    rv32_pkg::mem_write_t core_write;
    rv32_pkg::mem_write_t ram_write;
    rv32_pkg::word_t      word_addr;

    // Byte address from the ALU to word address
    assign word_addr = addr >> 2;

    // Store path from the execute slot
    always_comb begin
        // No store reaches the RAM while reset is held
        core_write.en   = rst_n && ex_ctrl.valid && ex_ctrl.opcode == rv32_pkg::OPC_STORE;
        core_write.addr = word_addr;
        core_write.data = ex_ctrl.store_data;
    end

    // Outside port owns the write side during program load
    assign ram_write = program_en ? dmem_write : core_write;

    // Load word lands with the registered ALU result
    rv32_bram #(
        .payload_t (rv32_pkg::word_t),
        .DEPTH     (DMEM_DEPTH)
    ) i_dmem (
        .clk     (clk),
        .write   (ram_write),
        .rd_addr (word_addr[DMEM_AW-1:0]),
        .rd_data (load_data)
    );

endmodule

`default_nettype wire

// File: logic/rv32_writeback.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_writeback (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv32_pkg::ex_result_t result,
    input  rv32_pkg::word_t      load_data,
    output rv32_pkg::rf_write_t  rf_write
);

    rv32_pkg::word_t wb_value;
    logic            wb_en;

    // Result source by instruction class
    always_comb begin
        case (result.opcode)
            rv32_pkg::OPC_LUI:  wb_value = result.imm;
            rv32_pkg::OPC_LOAD: wb_value = load_data;
            default:            wb_value = result.alu_result;
        endcase
    end

    // Stores, bubbles and x0 targets do not write
    assign wb_en = result.valid
                && result.opcode != rv32_pkg::OPC_STORE
                && result.opcode != rv32_pkg::OPC_NOP
                && result.rd != '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rf_write.en <= 1'b0;
        end else begin
            rf_write.en <= wb_en;
        end
    end

    // Value and target register
    always_ff @(posedge clk) begin
        rf_write.rd    <= result.rd;
        rf_write.value <= wb_value;
    end

endmodule

`default_nettype wire

// File: logic/rv32_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_core #(
    parameter int unsigned IMEM_DEPTH = 1024,
    parameter int unsigned DMEM_DEPTH = 1024
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 program_en,
    input  rv32_pkg::mem_write_t imem_write,
    input  rv32_pkg::mem_write_t dmem_write,
    output rv32_pkg::rf_write_t  retire
);

    // ========================================
    // Stage links
    // ========================================
    rv32_pkg::instr_t     instr;
    logic                 instr_valid;
    rv32_pkg::ex_ctrl_t   ex_ctrl;
    rv32_pkg::ex_result_t ex_result;
    rv32_pkg::word_t      mem_addr;
    rv32_pkg::word_t      load_data;
    rv32_pkg::rf_write_t  rf_write;

    rv32_fetch #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) i_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .program_en  (program_en),
        .imem_write  (imem_write),
        .instr       (instr),
        .instr_valid (instr_valid)
    );

    rv32_decode i_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .rf_write    (rf_write),
        .ex_ctrl     (ex_ctrl)
    );

    // ALU and data memory run side by side on one ex_ctrl
    rv32_alu i_alu (
        .ex_ctrl (ex_ctrl),
        .clk     (clk),
        .rst_n   (rst_n),
        .result  (ex_result),
        .addr    (mem_addr)
    );

    rv32_dmem_unit #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) i_dmem_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .program_en (program_en),
        .dmem_write (dmem_write),
        .ex_ctrl    (ex_ctrl),
        .addr       (mem_addr),
        .load_data  (load_data)
    );

    rv32_writeback i_writeback (
        .clk       (clk),
        .rst_n     (rst_n),
        .result    (ex_result),
        .load_data (load_data),
        .rf_write  (rf_write)
    );

    // Every register write is reported
    assign retire = rf_write;

endmodule

`default_nettype wire

// File: tb/rv32_core_properties.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_core_properties (
    input logic                clk,
    input logic                rst_n,
    input rv32_pkg::rf_write_t retire
);

    // Count of failed assertions
    int unsigned failure_count = 0;

    // ========================================
    // Retire port rules
    // ========================================
    // Quiet through reset and the cycle after it
    property quiet_in_reset;
        @(posedge clk) !rst_n |=> !retire.en;
    endproperty

    property no_x0_retire;
        @(posedge clk) disable iff (!rst_n) retire.en |-> retire.rd != '0;
    endproperty

    property retire_known;
        @(posedge clk) disable iff (!rst_n) retire.en |-> !$isunknown(retire);
    endproperty

    quiet_in_reset_a: assert property (quiet_in_reset) else begin
        failure_count++;
        $error("Retire valid during or right after reset");
    end

    no_x0_retire_a: assert property (no_x0_retire) else begin
        failure_count++;
        $error("Retire reported a write to x0");
    end

    retire_known_a: assert property (retire_known) else begin
        failure_count++;
        $error("Retire fields unknown while valid");
    end

endmodule

bind rv32_core rv32_core_properties i_rv32_core_properties (
    .clk    (clk),
    .rst_n  (rst_n),
    .retire (retire)
);

`default_nettype wire

// File: tb/rv32_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_core_tb;

    // ========================================
    // Sizes and run lengths
    // ========================================
    localparam int unsigned IMEM_DEPTH    = 1024;
    localparam int unsigned DMEM_DEPTH    = 1024;
    localparam int unsigned DATA_WORDS    = 40;
    localparam int unsigned PAD_NOPS      = 4;
    localparam int unsigned TAIL_NOPS     = 16;
    localparam int unsigned SETTLE_CYCLES = 10;

    logic                 clk;
    logic                 rst_n;
    logic                 program_en;
    rv32_pkg::mem_write_t imem_write;
    rv32_pkg::mem_write_t dmem_write;
    rv32_pkg::rf_write_t  retire;

    // Shadow state of the reference model
    rv32_pkg::word_t shadow_regs [32];
    rv32_pkg::word_t shadow_mem [DMEM_DEPTH];

    rv32_pkg::instr_t    program_q [$];
    rv32_pkg::rf_write_t expected_q [$];
    int unsigned         real_count;
    int unsigned         limit_cycles;
    bit                  run_started;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    rv32_core #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) i_rv32_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .program_en (program_en),
        .imem_write (imem_write),
        .dmem_write (dmem_write),
        .retire     (retire)
    );

    // ========================================
    // Instruction encoders
    // ========================================
    function automatic rv32_pkg::instr_t r_type(
        input logic                alt,
        input rv32_pkg::reg_addr_t rs2,
        input rv32_pkg::reg_addr_t rs1,
        input logic [2:0]          f3,
        input rv32_pkg::reg_addr_t rd
    );
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv32_pkg::OPCODE_OP};
    endfunction

    function automatic rv32_pkg::instr_t i_type(
        input logic [11:0]         imm,
        input rv32_pkg::reg_addr_t rs1,
        input logic [2:0]          f3,
        input rv32_pkg::reg_addr_t rd,
        input logic [6:0]          opc
    );
        return {imm, rs1, f3, rd, opc};
    endfunction

    // Encodes SW with funct3 set to the word width
    function automatic rv32_pkg::instr_t s_type(
        input logic [11:0]         imm,
        input rv32_pkg::reg_addr_t rs2,
        input rv32_pkg::reg_addr_t rs1
    );
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv32_pkg::OPCODE_STORE};
    endfunction

    function automatic rv32_pkg::instr_t u_type(
        input logic [19:0]         imm,
        input rv32_pkg::reg_addr_t rd
    );
        return {imm, rd, rv32_pkg::OPCODE_LUI};
    endfunction

    // ========================================
    // Reference model
    // ========================================
    // Integer operation selected by funct3 and instruction bit 30
    function automatic rv32_pkg::word_t alu_result(
        input logic [2:0]      f3,
        input logic            alt,
        input rv32_pkg::word_t a,
        input rv32_pkg::word_t b
    );
        logic signed [31:0] sra;

        sra = $signed(a) >>> b[4:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? rv32_pkg::word_t'(sra) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes one instruction on the shadow state and returns its register write
    function automatic rv32_pkg::rf_write_t expected_write(input rv32_pkg::instr_t ins);
        rv32_pkg::rf_write_t res;
        rv32_pkg::word_t     a;
        rv32_pkg::word_t     b;
        rv32_pkg::word_t     imm_i;
        rv32_pkg::word_t     imm_s;
        rv32_pkg::word_t     addr;
        logic [2:0]          f3;

        f3        = ins[14:12];
        a         = shadow_regs[ins[19:15]];
        b         = shadow_regs[ins[24:20]];
        imm_i     = {{20{ins[31]}}, ins[31:20]};
        imm_s     = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        res.en    = 1'b1;
        res.rd    = ins[11:7];
        res.value = '0;
        case (ins[6:0])
            rv32_pkg::OPCODE_OP: begin
                res.value = alu_result(f3, ins[30], a, b);
            end
            rv32_pkg::OPCODE_OP_IMM: begin
                // Bit 30 only matters for SRAI here
                res.value = alu_result(f3, ins[30] && f3 == 3'b101, a, imm_i);
            end
            rv32_pkg::OPCODE_LUI: begin
                res.value = {ins[31:12], 12'b0};
            end
            rv32_pkg::OPCODE_LOAD: begin
                addr      = a + imm_i;
                res.value = shadow_mem[(addr >> 2) % DMEM_DEPTH];
            end
            rv32_pkg::OPCODE_STORE: begin
                addr = a + imm_s;
                shadow_mem[(addr >> 2) % DMEM_DEPTH] = b;
                res.en = 1'b0;
            end
            default: begin
                res.en = 1'b0;
            end
        endcase
        // x0 is hardwired to zero
        if (res.rd == '0) begin
            res.en = 1'b0;
        end
        if (res.en) begin
            shadow_regs[res.rd] = res.value;
        end
        return res;
    endfunction

    // Instruction plus padding so results are visible to the next one
    function automatic void add_instr(input rv32_pkg::instr_t ins);
        rv32_pkg::rf_write_t exp;

        exp = expected_write(ins);
        program_q.push_back(ins);
        if (exp.en) begin
            expected_q.push_back(exp);
        end
        for (int i = 0; i < PAD_NOPS; i++) begin
            program_q.push_back(rv32_pkg::NOP_INSTR);
        end
        real_count++;
    endfunction

    // ========================================
    // Program
    // ========================================
    task automatic build_program();
        rv32_pkg::reg_addr_t rd;
        rv32_pkg::reg_addr_t rs1;
        rv32_pkg::reg_addr_t rs2;
        logic [2:0]          f3;
        logic                alt;
        logic [11:0]         imm;
        int unsigned         k;

        // Random known value in every register
        for (int r = 1; r < 32; r++) begin
            add_instr(u_type(20'($urandom()), 5'(r)));
            add_instr(i_type(12'($urandom()), 5'(r), 3'b000, 5'(r), rv32_pkg::OPCODE_OP_IMM));
        end

        // SRA sign fill and SLT against SLTU on a negative operand
        add_instr(u_type(20'h80000, 5'd1));
        add_instr(i_type(12'h404, 5'd1, 3'b101, 5'd2, rv32_pkg::OPCODE_OP_IMM));
        add_instr(i_type(12'd1, 5'd0, 3'b000, 5'd3, rv32_pkg::OPCODE_OP_IMM));
        add_instr(r_type(1'b0, 5'd3, 5'd1, 3'b010, 5'd4));
        add_instr(r_type(1'b0, 5'd3, 5'd1, 3'b011, 5'd5));
        add_instr(r_type(1'b1, 5'd3, 5'd1, 3'b101, 5'd6));

        // Random register forms
        for (int n = 0; n < 40; n++) begin
            f3  = 3'($urandom_range(7, 0));
            alt = (f3 == 3'b000 || f3 == 3'b101) ? 1'($urandom_range(1, 0)) : 1'b0;
            rd  = 5'($urandom_range(31, 1));
            rs1 = 5'($urandom_range(31, 0));
            rs2 = 5'($urandom_range(31, 0));
            add_instr(r_type(alt, rs2, rs1, f3, rd));
        end

        // Three immediate forms of each funct3
        for (int n = 0; n < 24; n++) begin
            f3  = 3'(n % 8);
            imm = 12'($urandom());
            // Shift immediates carry shamt and the SRA bit only
            if (f3 == 3'b001) begin
                imm = {7'b0, imm[4:0]};
            end
            if (f3 == 3'b101) begin
                imm = {1'b0, imm[10], 5'b0, imm[4:0]};
            end
            rd  = 5'($urandom_range(31, 1));
            rs1 = 5'($urandom_range(31, 0));
            add_instr(i_type(imm, rs1, f3, rd, rv32_pkg::OPCODE_OP_IMM));
        end

        for (int n = 0; n < 6; n++) begin
            add_instr(u_type(20'($urandom()), 5'($urandom_range(31, 1))));
        end

        // Loads of preloaded words
        for (int n = 0; n < 10; n++) begin
            k  = $urandom_range(DATA_WORDS - 1, 0);
            rd = 5'($urandom_range(31, 1));
            add_instr(i_type(12'(k * 4), 5'd0, 3'b010, rd, rv32_pkg::OPCODE_LOAD));
        end

        // Store then reload through a base register with offsets across zero
        add_instr(i_type(12'd400, 5'd0, 3'b000, 5'd7, rv32_pkg::OPCODE_OP_IMM));
        for (int n = 0; n < 6; n++) begin
            imm = 12'(4 * n - 12);
            rs2 = 5'($urandom_range(31, 8));
            rd  = 5'($urandom_range(31, 8));
            add_instr(s_type(imm, rs2, 5'd7));
            add_instr(i_type(imm, 5'd7, 3'b010, rd, rv32_pkg::OPCODE_LOAD));
        end

        // Writes to x0 vanish and reads of x0 give zero
        add_instr(i_type(12'd123, 5'd0, 3'b000, 5'd0, rv32_pkg::OPCODE_OP_IMM));
        add_instr(r_type(1'b0, 5'd9, 5'd8, 3'b000, 5'd0));
        add_instr(i_type(12'd0, 5'd0, 3'b010, 5'd0, rv32_pkg::OPCODE_LOAD));
        add_instr(r_type(1'b0, 5'd0, 5'd0, 3'b110, 5'd9));
        add_instr(i_type(12'h055, 5'd0, 3'b110, 5'd10, rv32_pkg::OPCODE_OP_IMM));

        // NOP tail keeps fetch off unwritten memory
        for (int n = 0; n < TAIL_NOPS; n++) begin
            program_q.push_back(rv32_pkg::NOP_INSTR);
        end
    endtask

    // ========================================
    // Loading and checking
    // ========================================
    task automatic write_data_word(input int unsigned idx, input rv32_pkg::word_t data);
        @(negedge clk);
        dmem_write.en   = 1'b1;
        dmem_write.addr = idx;
        dmem_write.data = data;
    endtask

    task automatic write_instr_word(input int unsigned idx, input rv32_pkg::instr_t ins);
        @(negedge clk);
        imem_write.en   = 1'b1;
        imem_write.addr = idx;
        imem_write.data = ins;
    endtask

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_retire(input rv32_pkg::rf_write_t exp, input rv32_pkg::rf_write_t act);
        if (act.rd !== exp.rd || act.value !== exp.value) begin
            stop_with_failure($sformatf(
                "[ERROR] %0t: retire expected x%0d = %08h, got x%0d = %08h",
                $time, exp.rd, exp.value, act.rd, act.value));
        end
    endtask

    initial begin : main
        rst_n      = 1'b0;
        program_en = 1'b1;
        imem_write = '0;
        dmem_write = '0;
        void'($urandom(49));
        for (int r = 0; r < 32; r++) begin
            shadow_regs[r] = '0;
        end

        // Reset for three cycles
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < DATA_WORDS; i++) begin
            shadow_mem[i] = $urandom();
            write_data_word(i, shadow_mem[i]);
        end
        @(negedge clk);
        dmem_write = '0;

        build_program();
        limit_cycles = program_q.size() + 2 + real_count * 5 + 100 + SETTLE_CYCLES;

        for (int i = 0; i < program_q.size(); i++) begin
            write_instr_word(i, program_q[i]);
        end
        // Fetch starts at RESET_PC once program drops
        @(negedge clk);
        imem_write  = '0;
        program_en  = 1'b0;
        run_started = 1'b1;

        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        // A few more cycles to catch stray retires
        repeat (SETTLE_CYCLES) @(negedge clk);
        if (i_rv32_core.i_rv32_core_properties.failure_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_with_failure("An assertion on the retire port failed");
        end
    end

    // Compares each retire at the falling edge where it is stable
    initial begin : compare
        rv32_pkg::rf_write_t exp;

        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (i_rv32_core.i_rv32_core_properties.failure_count != 0) begin
                stop_with_failure("An assertion on the retire port failed");
            end
            if (retire.en === 1'b1) begin
                if (!run_started) begin
                    stop_with_failure("Retire went valid while the program was loading");
                end else if (expected_q.size() == 0) begin
                    stop_with_failure("Retire went valid with no result left to expect");
                end else begin
                    exp = expected_q.pop_front();
                    check_retire(exp, retire);
                end
            end else if (retire.en !== 1'b0) begin
                stop_with_failure("Retire valid went unknown after reset");
            end
        end
    end

    // Watchdog sized once the program is known
    initial begin : watchdog
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        stop_with_failure($sformatf(
            "Retirements stopped, %0d results still expected after %0d cycles",
            expected_q.size(), limit_cycles));
    end

endmodule

`default_nettype wire

// File: rv32_core.f
logic/rv32_pkg.sv
logic/rv32_bram.sv
logic/rv32_fetch.sv
logic/rv32_decode.sv
logic/rv32_alu.sv
logic/rv32_dmem_unit.sv
logic/rv32_writeback.sv
logic/rv32_core.sv
tb/rv32_core_properties.sv
tb/rv32_core_tb.sv

// File: Bender.yml
package:
  name: rv32_core

sources:
  # Core RTL in compile order
  - logic/rv32_pkg.sv
  - logic/rv32_bram.sv
  - logic/rv32_fetch.sv
  - logic/rv32_decode.sv
  - logic/rv32_alu.sv
  - logic/rv32_dmem_unit.sv
  - logic/rv32_writeback.sv
  - logic/rv32_core.sv
  # Testbench and bound assertions
  - target: test
    files:
      - tb/rv32_core_properties.sv
      - tb/rv32_core_tb.sv
